// ==== flist.f ====
source/pr_pkg.sv
source/pr_csr.sv
source/pr_sched.sv
source/pr_rank_buf.sv
source/pr_mac.sv
source/pr_top.sv
bench/pr_checker.sv
bench/pr_tb.sv

// ==== Makefile ====
# Verilator simulation of the rank-update accelerator
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= pr_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/pr_tb.sv ====
/*
 * rank-update accelerator testbench
 * host driver, byte memory model, reference rank update and compare
 */
`timescale 1ns/10ps
`default_nettype none

module pr_tb;

  import pr_pkg::*;

  localparam int n               = 8;
  localparam int mem_bytes       = 1024;
  localparam int host_timeout    = 2000;
  localparam int compare_timeout = 10;

  logic      clk;
  logic      reset;
  pr_req_t   pr_req_msg;
  logic      pr_req_val;
  logic      pr_req_rdy;
  pr_resp_t  pr_resp_msg;
  logic      pr_resp_val;
  logic      pr_resp_rdy;
  mem_req_t  mem_req_msg;
  logic      mem_req_val;
  logic      mem_req_rdy;
  mem_resp_t mem_resp_msg;
  logic      mem_resp_val;
  logic      mem_resp_rdy;

  integer seed = 9072;
  int     checks = 0;
  int     value_errors = 0;
  int     other_errors = 0;
  int     compares_done = 0;
  int     req_count = 0;
  bit     stall_en = 1'b0;
  addr_t  run_base_r;
  event   compare_ev;

  // byte memory and the data loaded for the current run
  logic [7:0] mem [mem_bytes];
  elem_t      g_ref [n][n];
  elem_t      r_ref [n];
  mem_op_e    exp_op [$];
  addr_t      exp_addr [$];

  pr_top #(.n(n)) UUT (
    .clk, .reset,
    .pr_req_msg, .pr_req_val, .pr_req_rdy,
    .pr_resp_msg, .pr_resp_val, .pr_resp_rdy,
    .mem_req_msg, .mem_req_val, .mem_req_rdy,
    .mem_resp_msg, .mem_resp_val, .mem_resp_rdy
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------------------------
  // reporting
  // ----------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("ERROR at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    other_errors++;
    $display("timeout: %s", what);
    finish_run();
  endtask

  // r_new[j] = sum over i of G[j][i] * r[i], mod 256
  function automatic elem_t ref_rank(input int j);
    int sum;
    sum = 0;
    for (int i = 0; i < n; i++) begin
      sum += int'(g_ref[j][i]) * int'(r_ref[i]);
    end
    return elem_t'(sum % 256);
  endfunction

  // ready or valid draw, always ready without stalls
  function automatic bit ready_draw();
    if (!stall_en) begin
      return 1'b1;
    end
    return (($random(seed) & 3) != 0);
  endfunction

  // ----------------------------------------------------------
  // memory model
  // ----------------------------------------------------------

  initial begin : memory_model
    bit        pending;
    mem_req_t  req;
    mem_resp_t resp;
    pending      = 1'b0;
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp_msg = '0;
    for (int a = 0; a < mem_bytes; a++) begin
      mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
    end
    forever begin
      @(posedge clk);
      if (reset) begin
        pending = 1'b0;
        mem_req_rdy  <= 1'b0;
        mem_resp_val <= 1'b0;
      end else begin
        // response ready only while a request is in flight
        check_value("mem_resp_rdy", 32'(mem_resp_rdy), 32'(pending));
        if (mem_resp_val && mem_resp_rdy) begin
          pending = 1'b0;
        end
        if (mem_req_val && mem_req_rdy) begin
          req = mem_req_msg;
          req_count++;
          if (exp_addr.size() == 0) begin
            other_errors++;
            $display("unexpected memory request to address 0x%0h", req.addr);
          end else begin
            check_value("mem_req_msg.op", 32'(req.op), 32'(exp_op.pop_front()));
            check_value("mem_req_msg.addr", req.addr, exp_addr.pop_front());
          end
          // little-endian word, byte 0 in the low lane
          resp.op   = req.op;
          resp.data = '0;
          for (int l = 0; l < 4; l++) begin
            if (req.op == mem_write) begin
              mem[int'(req.addr) + l] = req.data[8*l +: 8];
            end else begin
              resp.data[8*l +: 8] = mem[int'(req.addr) + l];
            end
          end
          mem_resp_msg <= resp;
          pending = 1'b1;
        end
        // a raised response holds until taken
        if (pending) begin
          mem_req_rdy  <= 1'b0;
          mem_resp_val <= mem_resp_val || ready_draw();
        end else begin
          mem_resp_val <= 1'b0;
          mem_req_rdy  <= ready_draw();
        end
      end
    end
  end

  // ----------------------------------------------------------
  // compare process
  // ----------------------------------------------------------

  initial begin : compare_proc
    forever begin
      @(compare_ev);
      for (int i = 0; i < n; i++) begin
        check_value($sformatf("r_new[%0d]", i), 32'(mem[int'(run_base_r) + i]),
                    32'(ref_rank(i)));
      end
      compares_done++;
    end
  end

  // ----------------------------------------------------------
  // host driver
  // ----------------------------------------------------------

  task automatic host_xfer(input pr_op_e req_op, input addr_t req_addr, input word_t req_data,
                           output pr_resp_t resp, output int stalled);
    int cycles;
    bit done;
    cycles  = 0;
    done    = 1'b0;
    stalled = 0;
    @(posedge clk);
    pr_req_msg  <= '{op: req_op, addr: req_addr, data: req_data};
    pr_req_val  <= 1'b1;
    pr_resp_rdy <= 1'b1;
    while (!done && cycles < host_timeout) begin
      @(posedge clk);
      cycles++;
      if (pr_req_val && pr_req_rdy) begin
        check_value("pr_resp_val", 32'(pr_resp_val), 32'(1));
        resp = pr_resp_msg;
        done = 1'b1;
      end else begin
        // held off, no response may show
        stalled++;
        check_value("pr_resp_val", 32'(pr_resp_val), 32'(0));
      end
    end
    pr_req_val  <= 1'b0;
    pr_resp_rdy <= 1'b0;
    if (!done) begin
      fail_timeout("host request never accepted");
    end
  endtask

  task automatic host_expect(input pr_op_e req_op, input addr_t req_addr,
                             input word_t req_data, input word_t exp_data,
                             output int stalled);
    pr_resp_t resp;
    host_xfer(req_op, req_addr, req_data, resp, stalled);
    check_value("pr_resp_msg.op", 32'(resp.op), 32'(req_op));
    check_value("pr_resp_msg.data", resp.data, exp_data);
  endtask

  // random G and R, plus the request sequence the run must produce
  task automatic load_case(input addr_t bg, input addr_t br);
    for (int j = 0; j < n; j++) begin
      for (int i = 0; i < n; i++) begin
        g_ref[j][i] = 8'($random(seed));
        mem[int'(bg) + n * j + i] = g_ref[j][i];
      end
    end
    for (int i = 0; i < n; i++) begin
      r_ref[i] = 8'($random(seed));
      mem[int'(br) + i] = r_ref[i];
    end
    exp_op.delete();
    exp_addr.delete();
    for (int w = 0; w < n / 4; w++) begin
      exp_op.push_back(mem_read);
      exp_addr.push_back(br + addr_t'(4 * w));
    end
    for (int j = 0; j < n; j++) begin
      for (int k = 0; k < n / 4; k++) begin
        exp_op.push_back(mem_read);
        exp_addr.push_back(bg + addr_t'(n * j + 4 * k));
      end
    end
    for (int w = 0; w < n / 4; w++) begin
      exp_op.push_back(mem_write);
      exp_addr.push_back(br + addr_t'(4 * w));
    end
    req_count = 0;
  endtask

  task automatic run_case(input bit stall, input addr_t bg, input addr_t br);
    int stalled;
    int cycles;
    int target;
    stall_en = stall;
    // base registers write and read back
    host_expect(pr_write, addr_t'(reg_base_g), bg, '0, stalled);
    host_expect(pr_write, addr_t'(reg_base_r), br, '0, stalled);
    host_expect(pr_read, addr_t'(reg_base_g), '0, bg, stalled);
    host_expect(pr_read, addr_t'(reg_base_r), '0, br, stalled);
    load_case(bg, br);
    run_base_r = br;
    host_expect(pr_write, addr_t'(reg_go), word_t'(1), '0, stalled);
    // this read only completes once the run is over
    host_expect(pr_read, addr_t'(reg_go), '0, word_t'(1), stalled);
    if (stalled == 0) begin
      other_errors++;
      $display("read of reg_go was not held off during the run");
    end
    check_value("memory request count", 32'(req_count), 32'(n / 4 + n * n / 4 + n / 4));
    check_value("missing memory requests", 32'(exp_addr.size()), 32'(0));
    target = compares_done + 1;
    -> compare_ev;
    cycles = 0;
    while (compares_done < target && cycles < compare_timeout) begin
      @(posedge clk);
      cycles++;
    end
    if (compares_done < target) begin
      fail_timeout("compare process did not finish");
    end
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin : main
    reset       = 1'b1;
    pr_req_msg  = '0;
    pr_req_val  = 1'b0;
    pr_resp_rdy = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    // no stalls, then stalls, then stalls on new bases
    run_case(1'b0, 32'h100, 32'h200);
    run_case(1'b1, 32'h100, 32'h200);
    run_case(1'b1, 32'h180, 32'h300);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== bench/pr_checker.sv ====
/*
 * handshake checker for the rank-update accelerator
 * message stability, single outstanding memory request, reset quiet
 */
`timescale 1ns/10ps
`default_nettype none

module pr_checker (
  input logic              clk,
  input logic              reset,
  input pr_pkg::pr_req_t   pr_req_msg,
  input logic              pr_req_val,
  input logic              pr_req_rdy,
  input pr_pkg::mem_req_t  mem_req_msg,
  input logic              mem_req_val,
  input logic              mem_req_rdy,
  input logic              mem_resp_val,
  input logic              mem_resp_rdy
);

  // memory request accepted, response not yet taken
  logic outstanding;

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 1'b0;
    end else if (mem_req_val && mem_req_rdy) begin
      outstanding <= 1'b1;
    end else if (mem_resp_val && mem_resp_rdy) begin
      outstanding <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // properties
  // ----------------------------------------------------------

  host_req_stable: assert property (@(posedge clk) disable iff (reset)
    (pr_req_val && !pr_req_rdy) |=> (pr_req_val && $stable(pr_req_msg)))
    else $error("host request dropped or changed before acceptance");

  mem_req_stable: assert property (@(posedge clk) disable iff (reset)
    (mem_req_val && !mem_req_rdy) |=> (mem_req_val && $stable(mem_req_msg)))
    else $error("memory request dropped or changed before acceptance");

  // no new request while one is in flight
  mem_req_single: assert property (@(posedge clk) disable iff (reset)
    outstanding |-> !mem_req_val)
    else $error("memory request raised with a response outstanding");

  mem_req_reset: assert property (@(posedge clk)
    (reset && $past(reset)) |-> !mem_req_val)
    else $error("memory request raised during reset");

endmodule

bind pr_top pr_checker handshake_check (
  .clk          (clk),
  .reset        (reset),
  .pr_req_msg   (pr_req_msg),
  .pr_req_val   (pr_req_val),
  .pr_req_rdy   (pr_req_rdy),
  .mem_req_msg  (mem_req_msg),
  .mem_req_val  (mem_req_val),
  .mem_req_rdy  (mem_req_rdy),
  .mem_resp_val (mem_resp_val),
  .mem_resp_rdy (mem_resp_rdy)
);

`default_nettype wire

// ==== source/pr_top.sv ====
/*
 * rank-update accelerator top level
 * host register block, scheduler, rank buffer and MAC
 */
`timescale 1ns/10ps
`default_nettype none

module pr_top #(
  parameter int n = 8
) (
  input  logic               clk,
  input  logic               reset,

  // host port
  input  pr_pkg::pr_req_t    pr_req_msg,
  input  logic               pr_req_val,
  output logic               pr_req_rdy,
  output pr_pkg::pr_resp_t   pr_resp_msg,
  output logic               pr_resp_val,
  input  logic               pr_resp_rdy,

  // memory port
  output pr_pkg::mem_req_t   mem_req_msg,
  output logic               mem_req_val,
  input  logic               mem_req_rdy,
  input  pr_pkg::mem_resp_t  mem_resp_msg,
  input  logic               mem_resp_val,
  output logic               mem_resp_rdy
);

  import pr_pkg::*;

  localparam int wbits = idx_bits(n / 4);
  localparam int jbits = idx_bits(n);

  // ----------------------------------------------------------
  // internal wiring
  // ----------------------------------------------------------

  logic             start;
  logic             busy;
  addr_t            base_g;
  addr_t            base_r;

  logic             r_load;
  logic [wbits-1:0] r_word_idx;
  logic [wbits-1:0] slice_idx;
  logic             mac_fire;
  logic             mac_first;
  logic             out_store;
  logic [jbits-1:0] out_idx;
  logic [wbits-1:0] out_word_idx;
  word_t            r_slice;
  word_t            out_word;
  elem_t            mac_sum;

  pr_csr csr (
    .clk, .reset,
    .pr_req_msg, .pr_req_val, .pr_req_rdy,
    .pr_resp_msg, .pr_resp_val, .pr_resp_rdy,
    .busy, .start, .base_g, .base_r
  );

  pr_sched #(.n(n)) sched (
    .clk, .reset, .start, .base_g, .base_r, .busy,
    .mem_req_msg, .mem_req_val, .mem_req_rdy,
    .mem_resp_val, .mem_resp_rdy,
    .r_load, .r_word_idx, .slice_idx,
    .mac_fire, .mac_first, .out_store, .out_idx,
    .out_word_idx, .out_word
  );

  // response data feeds both the rank loader and the MAC
  pr_rank_buf #(.n(n)) rank_buf (
    .clk, .reset,
    .r_load, .r_word_idx,
    .load_word (mem_resp_msg.data),
    .slice_idx, .r_slice,
    .out_store, .out_idx, .mac_sum,
    .out_word_idx, .out_word
  );

  pr_mac mac (
    .clk, .reset,
    .g_word (mem_resp_msg.data),
    .r_slice, .mac_fire, .mac_first, .mac_sum
  );

endmodule

`default_nettype wire

// ==== source/pr_mac.sv ====
/*
 * four-lane 8-bit multiply-accumulate
 * dot product of a G word and a rank slice, summed over one row
 */
`timescale 1ns/10ps
`default_nettype none

module pr_mac (
  input  logic           clk,
  input  logic           reset,
  input  pr_pkg::word_t  g_word,
  input  pr_pkg::word_t  r_slice,
  input  logic           mac_fire,
  input  logic           mac_first,
  output pr_pkg::elem_t  mac_sum
);

  import pr_pkg::*;

  elem_t acc;
  elem_t dot;

  // lane products, wrap at 256
  always_comb begin
    dot = '0;
    for (int l = 0; l < lanes; l++) begin
      dot = dot + elem_t'(g_word[l*elem_bits +: elem_bits] * r_slice[l*elem_bits +: elem_bits]);
    end
  end

  // first word of a row starts from zero
  assign mac_sum = (mac_first ? elem_t'(0) : acc) + dot;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (mac_fire) begin
      acc <= mac_sum;
    end
  end

endmodule

`default_nettype wire

// ==== source/pr_rank_buf.sv ====
/*
 * rank register files
 * rank-in loaded by word, rank-out stored by element, word views out
 */
`timescale 1ns/10ps
`default_nettype none

module pr_rank_buf #(
  parameter  int n     = 8,
  localparam int wbits = pr_pkg::idx_bits(n / 4),
  localparam int jbits = pr_pkg::idx_bits(n)
) (
  input  logic              clk,
  input  logic              reset,

  // rank-in side
  input  logic              r_load,
  input  logic [wbits-1:0]  r_word_idx,
  input  pr_pkg::word_t     load_word,
  input  logic [wbits-1:0]  slice_idx,
  output pr_pkg::word_t     r_slice,

  // rank-out side
  input  logic              out_store,
  input  logic [jbits-1:0]  out_idx,
  input  pr_pkg::elem_t     mac_sum,
  input  logic [wbits-1:0]  out_word_idx,
  output pr_pkg::word_t     out_word
);

  import pr_pkg::*;

  elem_t rank_in  [n];
  elem_t rank_out [n];

  // ----------------------------------------------------------
  // writes
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < n; i++) begin
        rank_in[i]  <= '0;
        rank_out[i] <= '0;
      end
    end else begin
      // little-endian lanes, lane 0 in the low byte
      if (r_load) begin
        for (int l = 0; l < lanes; l++) begin
          rank_in[int'(r_word_idx) * lanes + l] <= load_word[l*elem_bits +: elem_bits];
        end
      end
      if (out_store) begin
        rank_out[out_idx] <= mac_sum;
      end
    end
  end

  // ----------------------------------------------------------
  // word views
  // ----------------------------------------------------------

  always_comb begin
    for (int l = 0; l < lanes; l++) begin
      r_slice[l*elem_bits +: elem_bits]  = rank_in[int'(slice_idx) * lanes + l];
      out_word[l*elem_bits +: elem_bits] = rank_out[int'(out_word_idx) * lanes + l];
    end
  end

endmodule

`default_nettype wire

// ==== source/pr_sched.sv ====
/*
 * rank-update scheduler
 * FSM and counters, sequences R loads, G row reads and R write-back
 */
`timescale 1ns/10ps
`default_nettype none

module pr_sched #(
  parameter  int n     = 8,
  localparam int wbits = pr_pkg::idx_bits(n / 4),
  localparam int jbits = pr_pkg::idx_bits(n)
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  pr_pkg::addr_t     base_g,
  input  pr_pkg::addr_t     base_r,
  output logic              busy,

  // memory port
  output pr_pkg::mem_req_t  mem_req_msg,
  output logic              mem_req_val,
  input  logic              mem_req_rdy,
  input  logic              mem_resp_val,
  output logic              mem_resp_rdy,

  // buffer and MAC steering
  output logic              r_load,
  output logic [wbits-1:0]  r_word_idx,
  output logic [wbits-1:0]  slice_idx,
  output logic              mac_fire,
  output logic              mac_first,
  output logic              out_store,
  output logic [jbits-1:0]  out_idx,
  output logic [wbits-1:0]  out_word_idx,
  input  pr_pkg::word_t     out_word
);

  import pr_pkg::*;

  localparam logic [wbits-1:0] last_w   = wbits'(n / 4 - 1);
  localparam logic [jbits-1:0] last_j   = jbits'(n - 1);
  localparam addr_t            row_size = addr_t'(n);

  sched_state_e state;
  sched_state_e state_next;

  // R word, row and half counters
  logic [wbits-1:0] w;
  logic [jbits-1:0] j;
  logic [wbits-1:0] k;

  logic  resp_go;
  addr_t r_addr;
  addr_t g_addr;

  assign resp_go = mem_resp_val && mem_resp_rdy;
  assign r_addr  = base_r + addr_t'(w) * 4;
  assign g_addr  = base_g + row_size * addr_t'(j) + addr_t'(k) * 4;

  assign busy         = (state != st_idle);
  assign r_word_idx   = w;
  assign out_word_idx = w;
  assign slice_idx    = k;
  assign out_idx      = j;

  // ----------------------------------------------------------
  // state and counters
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      w     <= '0;
      j     <= '0;
      k     <= '0;
    end else begin
      state <= state_next;
      if (state == st_idle && start) begin
        w <= '0;
        j <= '0;
        k <= '0;
      end
      // R word counter, wraps for the write phase
      if ((state == st_wait_r || state == st_wait_w) && resp_go) begin
        w <= (w == last_w) ? '0 : w + 1'b1;
      end
      // half and row counters step on G responses
      if (state == st_wait_g && resp_go) begin
        k <= (k == last_w) ? '0 : k + 1'b1;
        if (k == last_w) begin
          j <= (j == last_j) ? '0 : j + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // next state and strobes
  // ----------------------------------------------------------

  always_comb begin
    state_next   = state;
    mem_req_val  = 1'b0;
    mem_resp_rdy = 1'b0;
    mem_req_msg  = '{op: mem_read, addr: r_addr, data: '0};
    r_load       = 1'b0;
    mac_fire     = 1'b0;
    mac_first    = (k == '0);
    out_store    = 1'b0;
    case (state)
      st_idle: begin
        if (start) state_next = st_read_r;
      end
      st_read_r: begin
        mem_req_val = 1'b1;
        if (mem_req_rdy) state_next = st_wait_r;
      end
      st_wait_r: begin
        mem_resp_rdy = 1'b1;
        r_load       = mem_resp_val;
        if (mem_resp_val) state_next = (w == last_w) ? st_read_g : st_read_r;
      end
      st_read_g: begin
        mem_req_val      = 1'b1;
        mem_req_msg.addr = g_addr;
        if (mem_req_rdy) state_next = st_wait_g;
      end
      st_wait_g: begin
        mem_resp_rdy = 1'b1;
        mac_fire     = mem_resp_val;
        // last word of the row lands in rank-out
        out_store    = mem_resp_val && (k == last_w);
        if (mem_resp_val) begin
          state_next = (k == last_w && j == last_j) ? st_write : st_read_g;
        end
      end
      st_write: begin
        mem_req_val      = 1'b1;
        mem_req_msg.op   = mem_write;
        mem_req_msg.data = out_word;
        if (mem_req_rdy) state_next = st_wait_w;
      end
      st_wait_w: begin
        mem_resp_rdy = 1'b1;
        if (mem_resp_val) state_next = (w == last_w) ? st_idle : st_write;
      end
      default: state_next = st_idle;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/pr_csr.sv ====
/*
 * host register block
 * val/rdy request decode, base address registers, go pulse
 */
`timescale 1ns/10ps
`default_nettype none

module pr_csr (
  input  logic              clk,
  input  logic              reset,

  // host request / response
  input  pr_pkg::pr_req_t   pr_req_msg,
  input  logic              pr_req_val,
  output logic              pr_req_rdy,
  output pr_pkg::pr_resp_t  pr_resp_msg,
  output logic              pr_resp_val,
  input  logic              pr_resp_rdy,

  // scheduler side
  input  logic              busy,
  output logic              start,
  output pr_pkg::addr_t     base_g,
  output pr_pkg::addr_t     base_r
);

  import pr_pkg::*;

  logic    accept;
  logic    is_write;
  pr_reg_e reg_sel;

  // ----------------------------------------------------------
  // handshake
  // ----------------------------------------------------------

  // request and response complete together, blocked while busy
  assign pr_req_rdy  = !busy && pr_resp_rdy;
  assign pr_resp_val = !busy && pr_req_val;
  assign accept      = pr_req_val && pr_req_rdy;

  assign is_write = (pr_req_msg.op == pr_write);
  assign reg_sel  = pr_reg_e'(pr_req_msg.addr);

  // ----------------------------------------------------------
  // registers
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      base_g <= '0;
      base_r <= '0;
      start  <= 1'b0;
    end else begin
      // one-cycle go pulse
      start <= accept && is_write && (reg_sel == reg_go);
      if (accept && is_write && (reg_sel == reg_base_g)) begin
        base_g <= pr_req_msg.data;
      end
      if (accept && is_write && (reg_sel == reg_base_r)) begin
        base_r <= pr_req_msg.data;
      end
    end
  end

  // ----------------------------------------------------------
  // response
  // ----------------------------------------------------------

  always_comb begin
    pr_resp_msg.op   = pr_req_msg.op;
    pr_resp_msg.data = '0;
    // writes always answer zero
    if (!is_write) begin
      case (reg_sel)
        reg_go:     pr_resp_msg.data = word_t'(1);
        reg_base_g: pr_resp_msg.data = base_g;
        reg_base_r: pr_resp_msg.data = base_r;
        default:    pr_resp_msg.data = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/pr_pkg.sv ====
/*
 * rank-update accelerator shared definitions
 * element and word widths, operation enums, message structs
 */
`default_nettype none

package pr_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------

  localparam int elem_bits = 8;
  localparam int word_bits = 32;
  localparam int lanes     = word_bits / elem_bits;

  typedef logic [elem_bits-1:0] elem_t;
  typedef logic [word_bits-1:0] word_t;
  typedef logic [31:0]          addr_t;

  // index width for a count, never below one bit
  function automatic int idx_bits(input int count);
    return (count > 1) ? $clog2(count) : 1;
  endfunction

  // ----------------------------------------------------------
  // opcodes and register map
  // ----------------------------------------------------------

  typedef enum logic {
    pr_read  = 1'b0,
    pr_write = 1'b1
  } pr_op_e;

  typedef enum logic [2:0] {
    mem_read  = 3'd0,
    mem_write = 3'd1
  } mem_op_e;

  // host register index, carried in the request address
  typedef enum logic [31:0] {
    reg_go     = 32'd0,
    reg_base_g = 32'd1,
    reg_base_r = 32'd2
  } pr_reg_e;

  // ----------------------------------------------------------
  // messages
  // ----------------------------------------------------------

  typedef struct packed {
    pr_op_e op;
    addr_t  addr;
    word_t  data;
  } pr_req_t;

  typedef struct packed {
    pr_op_e op;
    word_t  data;
  } pr_resp_t;

  typedef struct packed {
    mem_op_e op;
    addr_t   addr;
    word_t   data;
  } mem_req_t;

  typedef struct packed {
    mem_op_e op;
    word_t   data;
  } mem_resp_t;

  // scheduler FSM
  typedef enum logic [2:0] {
    st_idle,
    st_read_r,
    st_wait_r,
    st_read_g,
    st_wait_g,
    st_write,
    st_wait_w
  } sched_state_e;

endpackage

`default_nettype wire
